// File: verilog.f
+incdir+verif
rtl/core_cfg_pkg.sv
rtl/long_op_pkg.sv
rtl/long_hazard_unit.sv
rtl/int_regfile.sv
rtl/issue_ctrl.sv
rtl/mul_pipe.sv
rtl/div_iter.sv
rtl/retire_mux.sv
rtl/long_exec_core_top.sv
verif/tb_long_exec_core.sv

// File: Bender.yml
package:
  name: long_exec_core

sources:
  - rtl/core_cfg_pkg.sv
  - rtl/long_op_pkg.sv
  - rtl/long_hazard_unit.sv
  - rtl/int_regfile.sv
  - rtl/issue_ctrl.sv
  - rtl/mul_pipe.sv
  - rtl/div_iter.sv
  - rtl/retire_mux.sv
  - rtl/long_exec_core_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_long_exec_core.sv

// File: verif/tb_ref_model.svh
// reference results, model register file and pending writeback bookkeeping

// one expected register write, in program order
typedef struct packed {
    logic                    is_long; // mul or div, holds a hazard slot
    core_cfg_pkg::reg_addr_t rd;
    core_cfg_pkg::xword_t    data;
} exp_entry_t;

core_cfg_pkg::xword_t model_regs [32];    // state after every acked instr
exp_entry_t           exp_q [$];          // writebacks still owed, oldest first
core_cfg_pkg::xword_t last_wb_data [32];  // what the DUT last wrote per rd
int                   last_wb_cycle [32]; // cycle of that write

// expected value of one operation from its operands
function automatic core_cfg_pkg::xword_t ref_result(input long_op_pkg::long_op_e op,
                                                   input core_cfg_pkg::xword_t a,
                                                   input core_cfg_pkg::xword_t b,
                                                   input core_cfg_pkg::xword_t imm);
    core_cfg_pkg::xword_t r;
    case (op)
        long_op_pkg::OP_LI:   r = imm;
        long_op_pkg::OP_MUL:  r = a * b;                    // low 32 bits only
        long_op_pkg::OP_DIVU: r = (b == 0) ? '1 : a / b;    // div by zero gives all ones
        default:              r = (b == 0) ? a : a % b;     // remu, zero keeps dividend
    endcase
    return r;
endfunction

// oldest pending entry for rd, -1 if none
function automatic int find_pending(input core_cfg_pkg::reg_addr_t rd);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
        if (idx < 0 && exp_q[i].rd == rd) idx = i;
    end
    return idx;
endfunction

// File: verif/tb_long_exec_core.sv
// testbench for long_exec_core_top: clock, reset, stimulus, writeback compare, timeout
`timescale 1ns/1ps

module tb_long_exec_core;

    localparam int N_LI    = 32;  // one li per register, x0 included
    localparam int N_RAND  = 24;
    localparam int N_CHAIN = 8;
    localparam int N_WAW   = 4;
    localparam int N_BLOCK = 5;
    localparam int N_INSTR = N_LI + N_RAND + N_CHAIN + N_WAW + N_BLOCK;
    localparam int TIMEOUT_CYCLES = N_INSTR * 60 + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 instr_req_i;
    long_op_pkg::instr_t  instr_i;
    logic                 instr_ack_o;
    logic                 wb_valid_o;
    long_op_pkg::wb_t     wb_o;
    logic                 long_busy_o;
    int                   cycles;
    int                   ack_cycle;  // cycle of the latest ack

    `include "tb_ref_model.svh"

    long_exec_core_top #(.XLEN(32), .MUL_STAGES(3)) dut (
        .clk, .rst_n, .instr_req_i, .instr_i, .instr_ack_o,
        .wb_valid_o, .wb_o, .long_busy_o
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error: %s = %h, expected %h", what, got, exp));
        end
    endtask

    function automatic long_op_pkg::instr_t make_instr(input long_op_pkg::long_op_e op,
                                                       input int rd, input int rs1,
                                                       input int rs2,
                                                       input core_cfg_pkg::xword_t imm);
        long_op_pkg::instr_t ins;
        ins.op  = op;
        ins.rd  = core_cfg_pkg::reg_addr_t'(rd);
        ins.rs1 = core_cfg_pkg::reg_addr_t'(rs1);
        ins.rs2 = core_cfg_pkg::reg_addr_t'(rs2);
        ins.imm = imm;
        return ins;
    endfunction

    // full four-phase transfer of one instruction
    task automatic send_instr(input long_op_pkg::instr_t ins);
        core_cfg_pkg::xword_t val;
        exp_entry_t           e;
        @(posedge clk);
        #2;
        val = ref_result(ins.op, model_regs[ins.rs1], model_regs[ins.rs2], ins.imm);
        if (ins.rd != 0) begin // x0 owes no writeback
            e = '{is_long: ins.op != long_op_pkg::OP_LI, rd: ins.rd, data: val};
            exp_q.push_back(e);
        end
        instr_i     = ins;
        instr_req_i = 1'b1;
        do @(negedge clk); while (!instr_ack_o);
        ack_cycle = cycles;
        if (ins.rd != 0) model_regs[ins.rd] = val; // program order
        @(posedge clk);
        #2 instr_req_i = 1'b0;
        do @(negedge clk); while (instr_ack_o); // ack must fall before next req
    endtask

    // all owed writebacks seen, then the scoreboard must be empty
    task automatic wait_drained();
        do @(posedge clk); while (exp_q.size() != 0);
        @(negedge clk);
        check_value("long_busy_o", long_busy_o, 32'd0);
    endtask

    // timeout counter
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("timeout, the DUT stopped making progress");
            end
        end
    end

    // compare process, one writeback per cycle at most
    initial begin
        int idx;
        forever begin
            @(negedge clk);
            if (rst_n && wb_valid_o) begin
                idx = find_pending(wb_o.rd);
                if (idx < 0) begin
                    stop_with_failure($sformatf("writeback to x%0d without a pending instruction",
                                                wb_o.rd));
                end else begin
                    check_value("wb_o.data", wb_o.data, exp_q[idx].data);
                    if (exp_q[idx].is_long) check_value("long_busy_o", long_busy_o, 32'd1);
                    last_wb_data[wb_o.rd]  = wb_o.data;
                    last_wb_cycle[wb_o.rd] = cycles;
                    exp_q.delete(idx);
                end
            end
        end
    end

    initial begin
        int                   sel;
        int                   prev;
        int                   a_ack;
        int                   rs2;
        core_cfg_pkg::xword_t val;
        long_op_pkg::long_op_e op;
        void'($urandom(32'h678d_a0bc));
        ack_cycle   = 0;
        rst_n       = 1'b0;
        instr_req_i = 1'b0;
        instr_i     = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r]    = '0;
            last_wb_data[r]  = '0;
            last_wb_cycle[r] = 0;
        end
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        check_value("instr_ack_o", instr_ack_o, 32'd0);
        check_value("long_busy_o", long_busy_o, 32'd0);

        // li to every register, upper half kept small for divisors
        for (int r = 0; r < N_LI; r++) begin
            val = $urandom;
            if (r >= 8) val = val & 32'hff;
            send_instr(make_instr(long_op_pkg::OP_LI, r, 0, 0, val));
        end
        wait_drained();

        // random long ops, sources x1..x15 (x0 as zero divisor), dests x16..x31
        for (int k = 0; k < N_RAND; k++) begin
            sel = (k < 2) ? 1 - k : $urandom % 3; // div then mul first, retires out of order
            op  = (sel == 0) ? long_op_pkg::OP_MUL :
                  (sel == 1) ? long_op_pkg::OP_DIVU : long_op_pkg::OP_REMU;
            rs2 = ($urandom % 4 == 0) ? 0 : 1 + $urandom % 15;
            send_instr(make_instr(op, 16 + k % 16, 1 + $urandom % 15, rs2, '0));
        end
        wait_drained();

        // RAW chain, each op reads the previous rd
        prev = 16;
        for (int k = 0; k < N_CHAIN; k++) begin
            op = (k % 3 == 0) ? long_op_pkg::OP_MUL :
                 (k % 3 == 1) ? long_op_pkg::OP_DIVU : long_op_pkg::OP_REMU;
            send_instr(make_instr(op, 24 + k, prev, 8 + k, '0));
            prev = 24 + k;
        end
        wait_drained();

        // WAW on x20, final value compared at the end
        send_instr(make_instr(long_op_pkg::OP_DIVU, 20, 1, 9, '0));
        send_instr(make_instr(long_op_pkg::OP_MUL, 20, 2, 3, '0));
        send_instr(make_instr(long_op_pkg::OP_LI, 20, 0, 0, $urandom));
        send_instr(make_instr(long_op_pkg::OP_MUL, 20, 20, 4, '0));
        wait_drained();

        // long div in flight, three muls, then a second div that must wait
        send_instr(make_instr(long_op_pkg::OP_DIVU, 21, 5, 10, '0));
        a_ack = ack_cycle;
        check_value("long_busy_o", long_busy_o, 32'd1);
        send_instr(make_instr(long_op_pkg::OP_MUL, 22, 6, 7, '0));
        send_instr(make_instr(long_op_pkg::OP_MUL, 23, 11, 12, '0));
        send_instr(make_instr(long_op_pkg::OP_MUL, 25, 13, 14, '0));
        send_instr(make_instr(long_op_pkg::OP_REMU, 26, 1, 15, '0));
        check_value("x21 retired before blocked ack",
                    last_wb_cycle[21] > a_ack && last_wb_cycle[21] < ack_cycle, 32'd1);
        wait_drained();

        // last write per register must match program order
        for (int r = 1; r < 32; r++) begin
            check_value($sformatf("last wb_o.data x%0d", r), last_wb_data[r], model_regs[r]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: rtl/long_exec_core_top.sv
// top level of the long-latency back end, instances and wiring
`timescale 1ns/1ps

module long_exec_core_top #(
    parameter int XLEN       = core_cfg_pkg::xlen,
    parameter int MUL_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_req_i,
    input  long_op_pkg::instr_t instr_i,
    output logic                instr_ack_o,
    output logic                wb_valid_o,
    output long_op_pkg::wb_t    wb_o,
    output logic                long_busy_o
);

    core_cfg_pkg::reg_addr_t raddr_a, raddr_b, hz_rd, hz_rs1, hz_rs2;
    logic [XLEN-1:0]         rdata_a, rdata_b;
    logic                    hz_check_valid, hz_new_is_long, hz_rd_we, hz_issue, hz_stall;
    core_cfg_pkg::slot_id_t  hz_alloc_id, commit_id;
    logic                    commit_valid;
    logic                    mul_valid, div_valid, div_ready, div_grant;
    long_op_pkg::dispatch_t  disp;
    logic                    li_valid, li_ready;
    long_op_pkg::wb_t        li_wb;
    logic                    mul_res_valid, div_res_valid;
    long_op_pkg::result_t    mul_res, div_res;

    issue_ctrl u_issue (
        .clk, .rst_n, .instr_req_i, .instr_i, .instr_ack_o,
        .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .hz_check_valid_o(hz_check_valid), .hz_new_is_long_o(hz_new_is_long),
        .hz_rd_o(hz_rd), .hz_rs1_o(hz_rs1), .hz_rs2_o(hz_rs2), .hz_rd_we_o(hz_rd_we),
        .hz_issue_o(hz_issue), .hz_stall_i(hz_stall), .hz_alloc_id_i(hz_alloc_id),
        .mul_valid_o(mul_valid), .div_valid_o(div_valid), .disp_o(disp),
        .div_ready_i(div_ready), .li_valid_o(li_valid), .li_wb_o(li_wb),
        .li_ready_i(li_ready)
    );

    long_hazard_unit u_hazard (
        .clk, .rst_n, .check_valid_i(hz_check_valid), .new_is_long_i(hz_new_is_long),
        .rd_i(hz_rd), .rs1_i(hz_rs1), .rs2_i(hz_rs2), .rd_we_i(hz_rd_we),
        .issue_i(hz_issue), .commit_valid_i(commit_valid), .commit_id_i(commit_id),
        .stall_o(hz_stall), .alloc_id_o(hz_alloc_id), .long_busy_o
    );

    int_regfile #(.XLEN(XLEN)) u_regfile (
        .clk, .rst_n, .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b), .wb_valid_i(wb_valid_o), .wb_i(wb_o)
    );

    mul_pipe #(.XLEN(XLEN), .MUL_STAGES(MUL_STAGES)) u_mul (
        .clk, .rst_n, .valid_i(mul_valid), .disp_i(disp),
        .res_valid_o(mul_res_valid), .res_o(mul_res)
    );

    div_iter #(.XLEN(XLEN)) u_div (
        .clk, .rst_n, .valid_i(div_valid), .disp_i(disp), .ready_o(div_ready),
        .res_valid_o(div_res_valid), .res_o(div_res), .grant_i(div_grant)
    );

    retire_mux u_retire (
        .mul_valid_i(mul_res_valid), .mul_res_i(mul_res),
        .div_valid_i(div_res_valid), .div_res_i(div_res), .div_grant_o(div_grant),
        .li_valid_i(li_valid), .li_wb_i(li_wb), .li_ready_o(li_ready),
        .wb_valid_o, .wb_o, .commit_valid_o(commit_valid), .commit_id_o(commit_id)
    );

endmodule

// File: rtl/retire_mux.sv
// one result per cycle onto the write port: mul, then div, then li
`timescale 1ns/1ps

module retire_mux (
    input  logic                   mul_valid_i,
    input  long_op_pkg::result_t   mul_res_i,
    input  logic                   div_valid_i,
    input  long_op_pkg::result_t   div_res_i,
    output logic                   div_grant_o,
    input  logic                   li_valid_i,
    input  long_op_pkg::wb_t       li_wb_i,
    output logic                   li_ready_o,
    output logic                   wb_valid_o,
    output long_op_pkg::wb_t       wb_o,
    output logic                   commit_valid_o, // frees a hazard slot
    output core_cfg_pkg::slot_id_t commit_id_o
);

    // mul pipe cannot stall, so it always wins
    assign div_grant_o = div_valid_i && !mul_valid_i;
    assign li_ready_o  = !mul_valid_i && !div_valid_i;
    assign wb_valid_o  = mul_valid_i || div_valid_i || li_valid_i;

    always_comb begin
        if (mul_valid_i) begin
            wb_o = '{rd: mul_res_i.rd, data: mul_res_i.data};
        end else if (div_valid_i) begin
            wb_o = '{rd: div_res_i.rd, data: div_res_i.data};
        end else begin
            wb_o = li_wb_i;
        end
    end

    assign commit_valid_o = mul_valid_i || div_valid_i; // li holds no slot
    assign commit_id_o    = mul_valid_i ? mul_res_i.id : div_res_i.id;

endmodule

// File: rtl/div_iter.sv
// radix-2 restoring unsigned divider, result held until granted
`timescale 1ns/1ps

module div_iter #(
    parameter int XLEN = core_cfg_pkg::xlen
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_i,
    input  long_op_pkg::dispatch_t disp_i,
    output logic                   ready_o,
    output logic                   res_valid_o,
    output long_op_pkg::result_t   res_o,
    input  logic                   grant_i
);

    localparam int CW = $clog2(XLEN);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

    state_e                  state_q;
    logic [CW-1:0]           cnt_q;       // step index
    logic [XLEN-1:0]         quo_q;       // dividend shifts out, quotient in
    logic [XLEN-1:0]         rem_q;
    logic [XLEN-1:0]         dvs_q;
    long_op_pkg::long_op_e   op_q;
    core_cfg_pkg::slot_id_t  id_q;
    core_cfg_pkg::reg_addr_t rd_q;
    logic [XLEN:0]           trial;       // one extra bit for the borrow

    assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: if (valid_i) begin
                    state_q <= RUN;
                    cnt_q   <= '0;
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(XLEN - 1)) state_q <= DONE;
                end
                DONE:    if (grant_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // divisor 0: every trial passes, so quo = all ones and rem = dividend
    always_ff @(posedge clk) begin
        if (state_q == IDLE && valid_i) begin
            quo_q <= disp_i.a;
            rem_q <= '0;
            dvs_q <= disp_i.b;
            op_q  <= disp_i.op;
            id_q  <= disp_i.id;
            rd_q  <= disp_i.rd;
        end else if (state_q == RUN) begin
            rem_q <= trial[XLEN] ? {rem_q[XLEN-2:0], quo_q[XLEN-1]} : trial[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN]};
        end
    end

    assign ready_o     = state_q == IDLE;
    assign res_valid_o = state_q == DONE;
    assign res_o       = '{id: id_q, rd: rd_q,
                           data: (op_q == long_op_pkg::OP_REMU) ? rem_q : quo_q};

endmodule

// File: rtl/mul_pipe.sv
// pipelined multiplier, low XLEN product bits, id and rd carried along
`timescale 1ns/1ps

module mul_pipe #(
    parameter int XLEN       = core_cfg_pkg::xlen,
    parameter int MUL_STAGES = 3   // at least 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_i,
    input  long_op_pkg::dispatch_t disp_i,
    output logic                   res_valid_o,
    output long_op_pkg::result_t   res_o
);

    logic                    s0_v_q;     // stage 0: operands
    logic [XLEN-1:0]         s0_a_q, s0_b_q;
    core_cfg_pkg::slot_id_t  s0_id_q;
    core_cfg_pkg::reg_addr_t s0_rd_q;
    logic [XLEN-1:0]         prod_lo;
    logic [MUL_STAGES-1:1]   v_q;        // stage 1 product, then delay
    long_op_pkg::result_t    r_q [MUL_STAGES-1:1];

    assign prod_lo = s0_a_q * s0_b_q; // truncates to low half

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_v_q <= 1'b0;
            v_q    <= '0;
        end else begin
            s0_v_q <= valid_i;
            v_q    <= {v_q[MUL_STAGES-1:1] << 1} | (MUL_STAGES-1)'(s0_v_q);
        end
    end

    always_ff @(posedge clk) begin
        s0_a_q  <= disp_i.a;
        s0_b_q  <= disp_i.b;
        s0_id_q <= disp_i.id;
        s0_rd_q <= disp_i.rd;
        r_q[1]  <= '{id: s0_id_q, rd: s0_rd_q, data: prod_lo};
        for (int i = 2; i < MUL_STAGES; i++) begin
            r_q[i] <= r_q[i-1];
        end
    end

    assign res_valid_o = v_q[MUL_STAGES-1];
    assign res_o       = r_q[MUL_STAGES-1];

endmodule

// File: rtl/issue_ctrl.sv
// instruction intake FSM, operand read, stall decision and dispatch
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_req_i,
    input  long_op_pkg::instr_t     instr_i,
    output logic                    instr_ack_o,
    output core_cfg_pkg::reg_addr_t raddr_a_o,
    output core_cfg_pkg::reg_addr_t raddr_b_o,
    input  core_cfg_pkg::xword_t    rdata_a_i,
    input  core_cfg_pkg::xword_t    rdata_b_i,
    output logic                    hz_check_valid_o,
    output logic                    hz_new_is_long_o,
    output core_cfg_pkg::reg_addr_t hz_rd_o,
    output core_cfg_pkg::reg_addr_t hz_rs1_o,
    output core_cfg_pkg::reg_addr_t hz_rs2_o,
    output logic                    hz_rd_we_o,
    output logic                    hz_issue_o,
    input  logic                    hz_stall_i,
    input  core_cfg_pkg::slot_id_t  hz_alloc_id_i,
    output logic                    mul_valid_o,
    output logic                    div_valid_o,
    output long_op_pkg::dispatch_t  disp_o,
    input  logic                    div_ready_i,
    output logic                    li_valid_o,    // immediate write pending
    output long_op_pkg::wb_t        li_wb_o,
    input  logic                    li_ready_i     // retire_mux takes li this cycle
);

    typedef enum logic [1:0] {IDLE, ISSUE, ACK_WAIT} state_e;

    state_e state_q, state_d;
    logic   is_li, is_mul, is_div;
    logic   own_stall, issue;

    assign is_li  = instr_i.op == long_op_pkg::OP_LI;
    assign is_mul = instr_i.op == long_op_pkg::OP_MUL;
    assign is_div = !is_li && !is_mul; // divu or remu

    assign raddr_a_o = instr_i.rs1;
    assign raddr_b_o = instr_i.rs2;

    // li reads nothing, so its source fields must not stall
    assign hz_check_valid_o = state_q == ISSUE;
    assign hz_new_is_long_o = !is_li;
    assign hz_rd_o          = instr_i.rd;
    assign hz_rs1_o         = is_li ? '0 : instr_i.rs1;
    assign hz_rs2_o         = is_li ? '0 : instr_i.rs2;
    assign hz_rd_we_o       = instr_i.rd != '0;

    // a pending li is not in the regfile yet, hold everything behind it
    assign own_stall  = li_valid_o || (is_div && !div_ready_i);
    assign issue      = hz_check_valid_o && !hz_stall_i && !own_stall;
    assign hz_issue_o = issue;

    assign mul_valid_o = issue && is_mul;
    assign div_valid_o = issue && is_div;
    assign disp_o      = '{op: instr_i.op, id: hz_alloc_id_i, rd: instr_i.rd,
                           a: rdata_a_i, b: rdata_b_i};

    assign instr_ack_o = state_q == ACK_WAIT; // high the cycle after dispatch

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (instr_req_i) state_d = ISSUE;
            ISSUE:    if (issue) state_d = ACK_WAIT;
            ACK_WAIT: if (!instr_req_i) state_d = IDLE; // host dropped req
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            li_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (issue && is_li && instr_i.rd != '0) begin
                li_valid_o <= 1'b1; // li to x0 writes nothing
            end else if (li_ready_i) begin
                li_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue && is_li) begin
            li_wb_o <= '{rd: instr_i.rd, data: instr_i.imm};
        end
    end

endmodule

// File: rtl/int_regfile.sv
// 32-entry integer register file, 2 read ports, 1 write port, x0 tied to zero
`timescale 1ns/1ps

module int_regfile #(
    parameter int XLEN = core_cfg_pkg::xlen
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_cfg_pkg::reg_addr_t raddr_a_i,
    input  core_cfg_pkg::reg_addr_t raddr_b_i,
    output logic [XLEN-1:0]         rdata_a_o,
    output logic [XLEN-1:0]         rdata_b_o,
    input  logic                    wb_valid_i,
    input  long_op_pkg::wb_t        wb_i
);

    localparam int NREG = 2 ** $bits(core_cfg_pkg::reg_addr_t);

    logic [XLEN-1:0] regs_q [NREG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_valid_i && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data; // x0 write dropped
        end
    end

    // async reads, x0 stays 0 since never written
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// File: rtl/long_hazard_unit.sv
// scoreboard of in-flight long ops: RAW/WAW check, slot allocation, busy flag
`timescale 1ns/1ps

module long_hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    check_valid_i,  // instr waiting in ISSUE
    input  logic                    new_is_long_i,  // mul/div, needs a slot
    input  core_cfg_pkg::reg_addr_t rd_i,
    input  core_cfg_pkg::reg_addr_t rs1_i,
    input  core_cfg_pkg::reg_addr_t rs2_i,
    input  logic                    rd_we_i,
    input  logic                    issue_i,        // dispatch happens this edge
    input  logic                    commit_valid_i, // long result retiring
    input  core_cfg_pkg::slot_id_t  commit_id_i,
    output logic                    stall_o,
    output core_cfg_pkg::slot_id_t  alloc_id_o,     // lowest free slot
    output logic                    long_busy_o
);

    localparam int NSLOT = 2 ** $bits(core_cfg_pkg::slot_id_t);

    logic [NSLOT-1:0]        slot_v_q;            // slot holds a live op
    core_cfg_pkg::reg_addr_t slot_rd_q [NSLOT];   // its destination
    logic                    raw, waw, full;
    logic                    rs1_chk, rs2_chk, rd_chk;
    logic                    take;

    // x0 never collides
    assign rs1_chk = rs1_i != '0;
    assign rs2_chk = rs2_i != '0;
    assign rd_chk  = rd_we_i && (rd_i != '0);

    assign full = &slot_v_q;
    assign take = issue_i && new_is_long_i; // only long ops occupy a slot

    always_comb begin
        raw        = 1'b0;
        waw        = 1'b0;
        alloc_id_o = '0;
        // walk downwards so the lowest free index wins
        for (int i = NSLOT - 1; i >= 0; i--) begin
            if (!slot_v_q[i]) begin
                alloc_id_o = core_cfg_pkg::slot_id_t'(i);
            end else begin
                if ((rs1_chk && rs1_i == slot_rd_q[i]) ||
                    (rs2_chk && rs2_i == slot_rd_q[i])) begin
                    raw = 1'b1; // source still being computed
                end
                if (rd_chk && rd_i == slot_rd_q[i]) begin
                    waw = 1'b1; // would retire out of order
                end
            end
        end
    end

    // seen against table state before this edge's commit
    assign stall_o = check_valid_i && (raw || waw || (new_is_long_i && full));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_v_q <= '0;
        end else begin
            if (commit_valid_i) begin
                slot_v_q[commit_id_i] <= 1'b0;
            end
            // alloc slot is free, so never the same slot as the commit
            if (take) begin
                slot_v_q[alloc_id_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            slot_rd_q[alloc_id_o] <= rd_i;
        end
    end

    assign long_busy_o = |slot_v_q; // any mul/div outstanding

endmodule

// File: rtl/long_op_pkg.sv
// long operation enum, instruction, dispatch, result and writeback structs
package long_op_pkg;

    // operation select
    typedef enum logic [1:0] {
        OP_LI   = 2'd0, // load immediate, short path
        OP_MUL  = 2'd1, // low half of product
        OP_DIVU = 2'd2, // unsigned quotient
        OP_REMU = 2'd3  // unsigned remainder
    } long_op_e;

    // from the issue logic, 49 bits
    typedef struct packed {
        long_op_e               op;
        core_cfg_pkg::reg_addr_t rd;
        core_cfg_pkg::reg_addr_t rs1;
        core_cfg_pkg::reg_addr_t rs2;
        core_cfg_pkg::xword_t    imm; // only used by OP_LI
    } instr_t;

    // issue_ctrl to mul_pipe / div_iter, 73 bits
    typedef struct packed {
        long_op_e               op;
        core_cfg_pkg::slot_id_t  id;
        core_cfg_pkg::reg_addr_t rd;
        core_cfg_pkg::xword_t    a;   // rs1 value
        core_cfg_pkg::xword_t    b;   // rs2 value
    } dispatch_t;

    // unit result towards retire_mux, 39 bits
    typedef struct packed {
        core_cfg_pkg::slot_id_t  id;
        core_cfg_pkg::reg_addr_t rd;
        core_cfg_pkg::xword_t    data;
    } result_t;

    // register write port, 37 bits
    typedef struct packed {
        core_cfg_pkg::reg_addr_t rd;
        core_cfg_pkg::xword_t    data;
    } wb_t;

endpackage

// File: rtl/core_cfg_pkg.sv
// architectural widths and their typedefs
package core_cfg_pkg;

    // data width, default of every XLEN parameter
    localparam int xlen = 32;

    // register index, 32 architectural registers
    localparam int reg_addr_w = 5;

    // completion id width, sized for the four table slots
    localparam int slot_id_w = 2;

    // x0..x31
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // id handed out by the hazard unit for a long op
    typedef logic [slot_id_w-1:0] slot_id_t;

    // one data word
    typedef logic [xlen-1:0] xword_t;

endpackage
